// ==== logic/mcr3_pkg.sv ====
// Shared types and constants for the scrolling arcade board wrapper.
// The ROM map assumes the download layout of the board's ROM set:
// main, sound, csd, sprite, then background, packed back to back.
// game_none covers any mode byte the board does not know.
package mcr3_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [24:0] dl_addr_t;
	typedef logic [23:0] mem_addr_t;
	typedef logic [1:0]  mem_be_t;
	typedef logic [12:0] buttons_t;
	typedef logic [7:0]  analog_t;
	typedef logic [8:0]  spin_t;

	typedef enum logic [2:0] {
		region_main,
		region_sound,
		region_csd,
		region_sprite,
		region_background
	} region_e;

	typedef enum logic [1:0] {
		game_chase  = 2'd0,
		game_racing = 2'd1,
		game_crater = 2'd2,
		game_none   = 2'd3
	} game_e;

	// ROM map, download byte addresses
	localparam dl_addr_t SOUND_BASE  = 25'h000E000;
	localparam dl_addr_t CSD_BASE    = 25'h0010000;
	localparam dl_addr_t SPRITE_BASE = 25'h0018000;
	localparam dl_addr_t BG_BASE     = 25'h0028000;

	// Download stream indexes
	localparam byte_t IDX_ROM  = 8'd0;
	localparam byte_t IDX_MODE = 8'd1;
	localparam byte_t IDX_DIP  = 8'd254;

	localparam byte_t STEER_CENTER = 8'h70;

endpackage

// ==== logic/rom_loader.sv ====
// Turns the byte-wide download stream into memory writes.
// One write can be pending; while it waits, dl_ready stays low.
// Config beats (mode and DIP) never reach the write port.
// DIP beats at address 8 and above are accepted and dropped.
`timescale 1ns/1ps

module rom_loader (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                dl_active,
	input  logic                dl_valid,
	output logic                dl_ready,
	input  mcr3_pkg::byte_t     dl_index,
	input  mcr3_pkg::dl_addr_t  dl_addr,
	input  mcr3_pkg::byte_t     dl_data,
	output logic                mem_wr_valid,
	input  logic                mem_wr_ready,
	output mcr3_pkg::region_e   mem_wr_region,
	output mcr3_pkg::mem_addr_t mem_wr_addr,
	output mcr3_pkg::mem_be_t   mem_wr_be,
	output logic [15:0]         mem_wr_data,
	output logic                mode_we,
	output logic                dip_we,
	output logic [2:0]          cfg_sel,
	output mcr3_pkg::byte_t     cfg_data,
	output logic                rom_busy
);
	import mcr3_pkg::*;

	logic      is_rom;
	logic      accept;
	region_e   region_d;
	dl_addr_t  offset;
	mem_addr_t addr_d;

	assign is_rom   = (dl_index == IDX_ROM);
	assign dl_ready = !mem_wr_valid || mem_wr_ready;
	assign accept   = dl_valid && dl_ready;
	assign rom_busy = dl_active && is_rom;

	assign mode_we  = accept && (dl_index == IDX_MODE);
	assign dip_we   = accept && (dl_index == IDX_DIP) && (dl_addr[24:3] == '0);
	assign cfg_sel  = dl_addr[2:0];
	assign cfg_data = dl_data;

	// ==================================================================
	// Region decode and remap
	// ==================================================================
	always_comb begin
		if (dl_addr < SOUND_BASE) begin
			region_d = region_main;
			offset   = dl_addr;
		end else if (dl_addr < CSD_BASE) begin
			region_d = region_sound;
			offset   = dl_addr - SOUND_BASE;
		end else if (dl_addr < SPRITE_BASE) begin
			region_d = region_csd;
			offset   = dl_addr - CSD_BASE;
		end else if (dl_addr < BG_BASE) begin
			region_d = region_sprite;
			offset   = dl_addr - SPRITE_BASE;
		end else begin
			region_d = region_background;
			offset   = dl_addr - BG_BASE;
		end

		// CSD ROM is 16 bit wide, bit 14 picks the byte lane
		if (region_d == region_csd)
			addr_d = {offset[23:15], offset[13:0], offset[14]};
		else
			addr_d = offset[23:0];
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			mem_wr_valid <= 1'b0;
		else if (accept && is_rom)
			mem_wr_valid <= 1'b1;
		else if (mem_wr_ready)
			mem_wr_valid <= 1'b0;
	end

	// Payload only loads on an accepted ROM beat
	always_ff @(posedge clk_sys) begin
		if (accept && is_rom) begin
			mem_wr_region <= region_d;
			mem_wr_addr   <= addr_d;
			mem_wr_be     <= addr_d[0] ? 2'b10 : 2'b01;
			mem_wr_data   <= {dl_data, dl_data};
		end
	end

	property p_write_held;
		@(posedge clk_sys) disable iff (reset)
		(mem_wr_valid && !mem_wr_ready) |=>
			(mem_wr_valid && $stable(mem_wr_region) && $stable(mem_wr_addr) &&
			 $stable(mem_wr_be) && $stable(mem_wr_data));
	endproperty

	a_write_held: assert property (p_write_held)
		else $error("rom_loader: pending write changed under back-pressure");

endmodule

// ==== logic/config_regs.sv ====
// DIP switch bytes and game-select byte from the config beats.
// DIP bytes reset to FF, the game mode resets to none.
// Mode decode is a second register stage after the raw byte.
`timescale 1ns/1ps

module config_regs (
	input  logic            clk_sys,
	input  logic            reset,
	input  logic            mode_we,
	input  logic            dip_we,
	input  logic [2:0]      cfg_sel,
	input  mcr3_pkg::byte_t cfg_data,
	output mcr3_pkg::byte_t dip0,
	output mcr3_pkg::byte_t dip1,
	output mcr3_pkg::game_e game_mode
);
	import mcr3_pkg::*;

	byte_t dip_q [8];
	byte_t mode_raw;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < 8; i++)
				dip_q[i] <= 8'hFF;
			mode_raw <= 8'hFF;
		end else begin
			if (dip_we)
				dip_q[cfg_sel] <= cfg_data;
			if (mode_we)
				mode_raw <= cfg_data;
		end
	end

	// Second stage, game decode
	always_ff @(posedge clk_sys) begin
		if (reset)
			game_mode <= game_none;
		else begin
			case (mode_raw)
				8'd0:    game_mode <= game_chase;
				8'd1:    game_mode <= game_racing;
				8'd2:    game_mode <= game_crater;
				default: game_mode <= game_none;
			endcase
		end
	end

	// Port 3 switches and the service bank
	assign dip0 = dip_q[0];
	assign dip1 = dip_q[1];

endmodule

// ==== logic/reset_sequencer.sv ====
// Core reset control. The core stays in reset until the ROM download
// has ended, then gets one extra reset pulse RESET_HOLD cycles later.
// The board needs that second pulse to start cleanly.
// RESET_HOLD must be at least 1.
`timescale 1ns/1ps

module reset_sequencer #(
	parameter int RESET_HOLD = 65535
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic user_reset,
	input  logic rom_busy,
	output logic core_reset,
	output logic rom_loaded
);
	localparam int CNT_W = $clog2(RESET_HOLD + 1);

	logic             rom_busy_q;
	logic             hold;
	logic [CNT_W-1:0] count;

	assign hold = user_reset || !rom_loaded;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_busy_q <= 1'b0;
			rom_loaded <= 1'b0;
			count      <= CNT_W'(RESET_HOLD);
			core_reset <= 1'b1;
		end else begin
			rom_busy_q <= rom_busy;
			// End of the ROM download
			if (rom_busy_q && !rom_busy)
				rom_loaded <= 1'b1;

			if (hold)
				count <= CNT_W'(RESET_HOLD);
			else if (count != '0)
				count <= count - 1'b1;

			core_reset <= hold || (count == CNT_W'(1));
		end
	end

	a_count_range: assert property (
		@(posedge clk_sys) disable iff (reset) count <= CNT_W'(RESET_HOLD))
		else $error("reset_sequencer: counter above RESET_HOLD");

endmodule

// ==== logic/analog_select.sv ====
// Follows whichever of two analog sources moved last.
// src_b wins when both move in the same cycle.
// Output lags a move by two cycles; src_a is selected after reset.
`timescale 1ns/1ps

module analog_select (
	input  logic            clk_sys,
	input  logic            reset,
	input  mcr3_pkg::spin_t src_a,
	input  mcr3_pkg::spin_t src_b,
	output mcr3_pkg::spin_t sel_out
);
	import mcr3_pkg::*;

	spin_t src_a_q;
	spin_t src_b_q;
	logic  sel_b;

	// Source history for move detection and the output register
	always_ff @(posedge clk_sys) begin
		src_a_q <= src_a;
		src_b_q <= src_b;
		sel_out <= sel_b ? src_b : src_a;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			sel_b <= 1'b0;
		else if (src_b != src_b_q)
			sel_b <= 1'b1;
		else if (src_a != src_a_q)
			sel_b <= 1'b0;
	end

endmodule

// ==== logic/input_mapper.sv ====
// Builds the board input ports from both players' controls.
// Buttons of both players are merged; analog axes come from the
// player who pressed something last, player 1 winning a tie.
// Crater spinner direction buttons do not reach the ports.
`timescale 1ns/1ps

module input_mapper (
	input  logic               clk_sys,
	input  logic               reset,
	input  mcr3_pkg::game_e    game_mode,
	input  mcr3_pkg::buttons_t joy1,
	input  mcr3_pkg::buttons_t joy2,
	input  mcr3_pkg::analog_t  joy1_x,
	input  mcr3_pkg::analog_t  joy1_y,
	input  mcr3_pkg::analog_t  joy2_x,
	input  mcr3_pkg::analog_t  joy2_y,
	input  mcr3_pkg::spin_t    spin,
	input  mcr3_pkg::spin_t    paddle,
	input  logic               service,
	input  mcr3_pkg::byte_t    dip0,
	input  logic               analog_gas,
	input  logic               paddle_steer,
	input  logic               lamp_sel,
	output mcr3_pkg::byte_t    input_0,
	output mcr3_pkg::byte_t    input_1,
	output mcr3_pkg::byte_t    input_2,
	output mcr3_pkg::byte_t    input_3
);
	import mcr3_pkg::*;

	buttons_t joy;
	logic     p2_active;
	logic     p2_next;
	analog_t  axis_x;
	analog_t  axis_y;
	byte_t    steer_x;
	byte_t    steer_p;
	byte_t    gas;
	byte_t    gas_val;
	byte_t    analog_byte;
	byte_t    in0_d;
	byte_t    in1_d;
	byte_t    in2_d;

	assign joy = joy1 | joy2;

	// Active player, player 1 checked last so it wins
	always_comb begin
		p2_next = p2_active;
		if (joy2 != '0)
			p2_next = 1'b1;
		if (joy1 != '0)
			p2_next = 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			p2_active <= 1'b0;
		else
			p2_active <= p2_next;
	end

	assign axis_x = p2_next ? joy2_x : joy1_x;
	assign axis_y = p2_next ? joy2_y : joy1_y;

	// ==================================================================
	// Steering and gas
	// ==================================================================
	assign steer_x = STEER_CENTER + {axis_x[7], axis_x[7:1]};
	assign steer_p = STEER_CENTER + {~paddle[7], ~paddle[7], paddle[6:1]};

	always_comb begin
		if (axis_y[7])
			gas = 8'h00 - axis_y;
		else if (game_mode == game_racing)
			gas = axis_y;
		else
			gas = 8'h00;
	end

	assign gas_val     = analog_gas ? {gas[6:0], 1'b1} : 8'hFF;
	assign analog_byte = lamp_sel ? (paddle_steer ? steer_p : steer_x) : gas_val;

	// ==================================================================
	// Per-game port bytes, active low
	// ==================================================================
	always_comb begin
		in0_d = 8'hFF;
		in1_d = 8'hFF;
		in2_d = 8'hFF;
		case (game_mode)
			game_chase: begin
				in0_d = ~{service, 2'b00, joy[9], 3'b000, joy[10]};
				in1_d = ~{3'b000, joy[4], joy[6], joy[8], joy[5], joy[7]};
				in2_d = analog_byte;
			end
			game_racing: begin
				in0_d = ~{service, 2'b00, joy[9], 3'b000, joy[10]};
				in1_d = ~{3'b000, joy[8], joy[7], joy[6], joy[5], joy[4]};
				in2_d = analog_byte;
			end
			game_crater: begin
				in0_d = ~{service, 2'b00, joy[4], joy[8], joy[9], 1'b0, joy[10]};
				in1_d = spin[7:0];
				in2_d = ~{1'b0, joy[5], 1'b0, joy[6], joy[2], joy[3], 2'b00};
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		input_0 <= in0_d;
		input_1 <= in1_d;
		input_2 <= in2_d;
		input_3 <= dip0;
	end

endmodule

// ==== logic/mcr3_io_top.sv ====
// Control and input side of the scrolling arcade board wrapper.
// The memory write port goes to an external SDRAM controller.
// RESET_HOLD sets the delay of the second core reset pulse.
`timescale 1ns/1ps

module mcr3_io_top #(
	parameter int RESET_HOLD = 65535
) (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                user_reset,
	// Download stream
	input  logic                dl_active,
	input  logic                dl_valid,
	output logic                dl_ready,
	input  mcr3_pkg::byte_t     dl_index,
	input  mcr3_pkg::dl_addr_t  dl_addr,
	input  mcr3_pkg::byte_t     dl_data,
	// Memory write port
	output logic                mem_wr_valid,
	input  logic                mem_wr_ready,
	output mcr3_pkg::region_e   mem_wr_region,
	output mcr3_pkg::mem_addr_t mem_wr_addr,
	output mcr3_pkg::mem_be_t   mem_wr_be,
	output logic [15:0]         mem_wr_data,
	// Player controls
	input  mcr3_pkg::buttons_t  joy1,
	input  mcr3_pkg::buttons_t  joy2,
	input  mcr3_pkg::analog_t   joy1_x,
	input  mcr3_pkg::analog_t   joy1_y,
	input  mcr3_pkg::analog_t   joy2_x,
	input  mcr3_pkg::analog_t   joy2_y,
	input  mcr3_pkg::spin_t     spin1,
	input  mcr3_pkg::spin_t     spin2,
	input  mcr3_pkg::spin_t     pad1,
	input  mcr3_pkg::spin_t     pad2,
	input  logic                analog_gas,
	input  logic                paddle_steer,
	input  logic                lamp_sel,
	// Core side
	output logic                core_reset,
	output logic                rom_loaded,
	output mcr3_pkg::byte_t     input_0,
	output mcr3_pkg::byte_t     input_1,
	output mcr3_pkg::byte_t     input_2,
	output mcr3_pkg::byte_t     input_3
);
	import mcr3_pkg::*;

	logic       mode_we;
	logic       dip_we;
	logic [2:0] cfg_sel;
	byte_t      cfg_data;
	logic       rom_busy;
	byte_t      dip0;
	byte_t      dip1;
	game_e      game_mode;
	spin_t      spin;
	spin_t      paddle;

	rom_loader rom_loader_inst (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl_active     (dl_active),
		.dl_valid      (dl_valid),
		.dl_ready      (dl_ready),
		.dl_index      (dl_index),
		.dl_addr       (dl_addr),
		.dl_data       (dl_data),
		.mem_wr_valid  (mem_wr_valid),
		.mem_wr_ready  (mem_wr_ready),
		.mem_wr_region (mem_wr_region),
		.mem_wr_addr   (mem_wr_addr),
		.mem_wr_be     (mem_wr_be),
		.mem_wr_data   (mem_wr_data),
		.mode_we       (mode_we),
		.dip_we        (dip_we),
		.cfg_sel       (cfg_sel),
		.cfg_data      (cfg_data),
		.rom_busy      (rom_busy)
	);

	config_regs config_regs_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.mode_we   (mode_we),
		.dip_we    (dip_we),
		.cfg_sel   (cfg_sel),
		.cfg_data  (cfg_data),
		.dip0      (dip0),
		.dip1      (dip1),
		.game_mode (game_mode)
	);

	reset_sequencer #(
		.RESET_HOLD (RESET_HOLD)
	) reset_sequencer_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.user_reset (user_reset),
		.rom_busy   (rom_busy),
		.core_reset (core_reset),
		.rom_loaded (rom_loaded)
	);

	// Spinner and paddle follow the player who moved last
	analog_select spin_sel (
		.clk_sys (clk_sys),
		.reset   (reset),
		.src_a   (spin1),
		.src_b   (spin2),
		.sel_out (spin)
	);

	analog_select pad_sel (
		.clk_sys (clk_sys),
		.reset   (reset),
		.src_a   (pad1),
		.src_b   (pad2),
		.sel_out (paddle)
	);

	input_mapper input_mapper_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.game_mode    (game_mode),
		.joy1         (joy1),
		.joy2         (joy2),
		.joy1_x       (joy1_x),
		.joy1_y       (joy1_y),
		.joy2_x       (joy2_x),
		.joy2_y       (joy2_y),
		.spin         (spin),
		.paddle       (paddle),
		.service      (dip1[0]),
		.dip0         (dip0),
		.analog_gas   (analog_gas),
		.paddle_steer (paddle_steer),
		.lamp_sel     (lamp_sel),
		.input_0      (input_0),
		.input_1      (input_1),
		.input_2      (input_2),
		.input_3      (input_3)
	);

endmodule

// ==== tests/tb_mcr3_io.sv ====
// Testbench for the arcade board control and input wrapper.
// Replays tests/io_patterns.mem, run from the project root.
// Expected memory writes come from the ROM map region rule.
// Expected port bytes come from the pattern file.
// mem_wr_ready stalls are drawn from an LCG with a fixed seed.
`timescale 1ns/1ps

module tb_mcr3_io;
	import mcr3_pkg::*;

	localparam int RESET_HOLD = 20;
	localparam int MAX_PATTERNS = 64;

	logic               clk_sys = 1'b0;
	logic               reset;
	logic               user_reset;
	logic               dl_active;
	logic               dl_valid;
	logic               dl_ready;
	byte_t              dl_index;
	dl_addr_t           dl_addr;
	byte_t              dl_data;
	logic               mem_wr_valid;
	logic               mem_wr_ready = 1'b0;
	region_e            mem_wr_region;
	mem_addr_t          mem_wr_addr;
	mem_be_t            mem_wr_be;
	logic [15:0]        mem_wr_data;
	buttons_t           joy1;
	buttons_t           joy2;
	analog_t            joy1_x;
	analog_t            joy1_y;
	analog_t            joy2_x;
	analog_t            joy2_y;
	spin_t              spin1;
	spin_t              spin2;
	spin_t              pad1;
	spin_t              pad2;
	logic               analog_gas;
	logic               paddle_steer;
	logic               lamp_sel;
	logic               core_reset;
	logic               rom_loaded;
	byte_t              input_0;
	byte_t              input_1;
	byte_t              input_2;
	byte_t              input_3;

	logic [159:0] patterns [MAX_PATTERNS];
	int           pattern_count;
	int           cycle_limit = 1000000;
	int           cycles = 0;
	logic [31:0]  rng = 32'hd5e8;

	// ROM beats accepted and not yet seen at the write port
	dl_addr_t     exp_addr_q[$];
	byte_t        exp_data_q[$];

	// Write fields seen on the last stalled cycle
	logic         stalled = 1'b0;
	region_e      held_region;
	mem_addr_t    held_addr;
	mem_be_t      held_be;
	logic [15:0]  held_data;

	mcr3_io_top #(
		.RESET_HOLD (RESET_HOLD)
	) mcr3_io_top_inst (
		.clk_sys (clk_sys), .reset (reset), .user_reset (user_reset),
		.dl_active (dl_active), .dl_valid (dl_valid), .dl_ready (dl_ready),
		.dl_index (dl_index), .dl_addr (dl_addr), .dl_data (dl_data),
		.mem_wr_valid (mem_wr_valid), .mem_wr_ready (mem_wr_ready),
		.mem_wr_region (mem_wr_region), .mem_wr_addr (mem_wr_addr),
		.mem_wr_be (mem_wr_be), .mem_wr_data (mem_wr_data),
		.joy1 (joy1), .joy2 (joy2), .joy1_x (joy1_x), .joy1_y (joy1_y),
		.joy2_x (joy2_x), .joy2_y (joy2_y), .spin1 (spin1), .spin2 (spin2),
		.pad1 (pad1), .pad2 (pad2), .analog_gas (analog_gas),
		.paddle_steer (paddle_steer), .lamp_sel (lamp_sel),
		.core_reset (core_reset), .rom_loaded (rom_loaded),
		.input_0 (input_0), .input_1 (input_1), .input_2 (input_2), .input_3 (input_3)
	);

	always #5 clk_sys = ~clk_sys;

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "testbench stopped");
	endtask

	task automatic check_write(input string name, input region_e er, input mem_addr_t ea,
			input mem_be_t eb, input logic [15:0] ed, input region_e ar,
			input mem_addr_t aa, input mem_be_t ab, input logic [15:0] ad);
		if (ar !== er || aa !== ea || ab !== eb || ad !== ed)
			stop_run($sformatf("Fail %s: expected %s %h %b %h, actual %s %h %b %h",
				name, er.name(), ea, eb, ed, ar.name(), aa, ab, ad));
	endtask

	task automatic check_port(input string name, input byte_t exp, input byte_t act);
		if (act !== exp)
			stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ==================================================================
	// Reference model of the ROM map
	// ==================================================================
	function automatic region_e region_of(input dl_addr_t a);
		if (a < SOUND_BASE)
			return region_main;
		if (a < CSD_BASE)
			return region_sound;
		if (a < SPRITE_BASE)
			return region_csd;
		if (a < BG_BASE)
			return region_sprite;
		return region_background;
	endfunction

	function automatic mem_addr_t remap_of(input dl_addr_t a);
		dl_addr_t off;
		case (region_of(a))
			region_main:   off = a;
			region_sound:  off = a - SOUND_BASE;
			region_sprite: off = a - SPRITE_BASE;
			region_csd: begin
				off = a - CSD_BASE;
				// Byte lane bit 14 moves to bit 0
				off = ((off & 25'h3FFF) << 1) | ((off >> 14) & 25'h1) | (off & ~25'h7FFF);
			end
			default:       off = a - BG_BASE;
		endcase
		return off[23:0];
	endfunction

	always @(negedge clk_sys) begin
		rng = lcg_next(rng);
		mem_wr_ready = rng[16];
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > cycle_limit)
			stop_run($sformatf("Run did not finish within %0d cycles", cycle_limit));
	end

	// Write port monitor
	always @(posedge clk_sys) begin
		mem_addr_t ea;
		if (!reset) begin
			if (dl_active)
				check_bit("core_reset during download", 1'b1, core_reset);
			if (stalled)
				check_write("stalled write held", held_region, held_addr, held_be, held_data,
					mem_wr_region, mem_wr_addr, mem_wr_be, mem_wr_data);
			if (mem_wr_valid && mem_wr_ready) begin
				if (exp_addr_q.size() == 0)
					stop_run("A memory write appeared with no ROM beat behind it");
				ea = remap_of(exp_addr_q[0]);
				check_write($sformatf("write for beat %h", exp_addr_q[0]),
					region_of(exp_addr_q[0]), ea, ea[0] ? 2'b10 : 2'b01,
					{exp_data_q[0], exp_data_q[0]},
					mem_wr_region, mem_wr_addr, mem_wr_be, mem_wr_data);
				void'(exp_addr_q.pop_front());
				void'(exp_data_q.pop_front());
			end
			if (dl_valid && dl_ready && dl_index == IDX_ROM) begin
				exp_addr_q.push_back(dl_addr);
				exp_data_q.push_back(dl_data);
			end
			stalled     = mem_wr_valid && !mem_wr_ready;
			held_region = mem_wr_region;
			held_addr   = mem_wr_addr;
			held_be     = mem_wr_be;
			held_data   = mem_wr_data;
		end
	end

	task automatic send_beat(input logic [159:0] v);
		logic taken;
		@(negedge clk_sys);
		dl_valid = 1'b1;
		dl_index = v[151:144];
		dl_addr  = v[136:112];
		dl_data  = v[111:104];
		taken    = 1'b0;
		while (!taken) begin
			@(posedge clk_sys);
			taken = dl_ready;
		end
		@(negedge clk_sys);
		dl_valid = 1'b0;
	endtask

	// Ends the ROM download and follows the core reset sequence
	task automatic end_download();
		int low_cycles;
		while (exp_addr_q.size() != 0 || mem_wr_valid)
			@(negedge clk_sys);
		check_bit("rom_loaded before end", 1'b0, rom_loaded);
		dl_active = 1'b0;
		while (core_reset)
			@(negedge clk_sys);
		check_bit("rom_loaded after end", 1'b1, rom_loaded);
		low_cycles = 1;
		@(negedge clk_sys);
		while (!core_reset) begin
			low_cycles++;
			@(negedge clk_sys);
		end
		// Counter reloads to RESET_HOLD and pulses when it reaches 1
		if (low_cycles != RESET_HOLD - 1)
			stop_run($sformatf("Fail second reset delay: expected %0d, actual %0d",
				RESET_HOLD - 1, low_cycles));
		@(negedge clk_sys);
		check_bit("second reset pulse width", 1'b0, core_reset);
		user_reset = 1'b1;
		@(negedge clk_sys);
		check_bit("core_reset from user_reset", 1'b1, core_reset);
		user_reset = 1'b0;
	endtask

	task automatic apply_controls(input int n, input logic [159:0] v);
		@(negedge clk_sys);
		analog_gas   = v[154];
		paddle_steer = v[153];
		lamp_sel     = v[152];
		joy1   = v[148:136];
		joy2   = v[132:120];
		joy1_x = v[119:112];
		joy1_y = v[111:104];
		joy2_x = v[103:96];
		joy2_y = v[95:88];
		spin1  = v[84:76];
		spin2  = v[72:64];
		pad1   = v[60:52];
		pad2   = v[48:40];
		// Two cycles of source select, one of port register, one spare
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check_port($sformatf("vector %0d input_0", n), v[31:24], input_0);
		check_port($sformatf("vector %0d input_1", n), v[23:16], input_1);
		check_port($sformatf("vector %0d input_2", n), v[15:8], input_2);
		check_port($sformatf("vector %0d input_3", n), v[7:0], input_3);
	endtask

	initial begin
		reset = 1'b1;
		user_reset = 1'b0;
		dl_active = 1'b0;
		dl_valid = 1'b0;
		dl_index = '0;
		dl_addr = '0;
		dl_data = '0;
		{joy1, joy2, joy1_x, joy1_y, joy2_x, joy2_y} = '0;
		{spin1, spin2, pad1, pad2} = '0;
		{analog_gas, paddle_steer, lamp_sel} = '0;

		for (int i = 0; i < MAX_PATTERNS; i++)
			patterns[i] = '0;
		$readmemh("tests/io_patterns.mem", patterns);
		pattern_count = 0;
		for (int i = 0; i < MAX_PATTERNS; i++)
			if (patterns[i][159:156] != 4'h0)
				pattern_count++;
		if (pattern_count == 0)
			stop_run("Pattern file tests/io_patterns.mem is missing or empty");
		cycle_limit = pattern_count * 40;

		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		check_bit("mem_wr_valid after reset", 1'b0, mem_wr_valid);
		check_bit("dl_ready after reset", 1'b1, dl_ready);
		check_bit("core_reset after reset", 1'b1, core_reset);

		for (int i = 0; i < pattern_count; i++) begin
			case (patterns[i][159:156])
				4'h1: send_beat(patterns[i]);
				4'h2: begin
					@(negedge clk_sys);
					dl_index  = IDX_ROM;
					dl_active = 1'b1;
				end
				4'h3: end_download();
				4'h4: apply_controls(i, patterns[i]);
				default: stop_run($sformatf("Pattern %0d has an unknown kind", i));
			endcase
		end

		if (exp_addr_q.size() != 0)
			stop_run("ROM beats were accepted but never written");
		else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

// ==== tests/io_patterns.mem ====
// kind 1 beat: kind flags index addr(8) data, rest zero; kind 2 start, kind 3 end download
// kind 4: kind flags joy1 joy2 j1x j1y j2x j2y spin1 spin2 pad1 pad2 00 in0 in1 in2 in3
4_0_0000_0000_00_00_00_00_000_000_000_000_00_ff_ff_ff_ff
2_000000000_0000000000_0000000000_0000000000
1_0_00_00000000_11_000000_0000000000_0000000000
1_0_00_00000001_22_000000_0000000000_0000000000
1_0_00_0000e000_33_000000_0000000000_0000000000
1_0_00_0000e005_44_000000_0000000000_0000000000
1_0_00_00010000_55_000000_0000000000_0000000000
1_0_00_00014003_66_000000_0000000000_0000000000
1_0_00_00017fff_bb_000000_0000000000_0000000000
1_0_00_00018002_77_000000_0000000000_0000000000
1_0_00_00027fff_88_000000_0000000000_0000000000
1_0_00_00028000_99_000000_0000000000_0000000000
1_0_00_00030001_aa_000000_0000000000_0000000000
3_000000000_0000000000_0000000000_0000000000
1_0_01_00000000_00_000000_0000000000_0000000000
1_0_fe_00000000_5a_000000_0000000000_0000000000
1_0_fe_00000001_01_000000_0000000000_0000000000
1_0_fe_00000009_00_000000_0000000000_0000000000
1_0_fe_00000008_00_000000_0000000000_0000000000
4_5_0000_0000_00_00_00_00_000_000_000_000_00_7f_ff_70_5a
4_5_0410_0000_20_00_00_00_000_000_000_000_00_7e_ef_80_5a
4_5_0000_0020_40_00_e0_00_000_000_000_000_00_7f_fd_60_5a
4_4_0000_0000_00_80_00_f0_000_000_000_000_00_7f_ff_21_5a
4_0_0000_0000_00_00_00_00_000_000_000_000_00_7f_ff_ff_5a
4_7_0000_0000_00_00_00_00_000_000_0c4_000_00_7f_ff_92_5a
1_0_01_00000000_01_000000_0000000000_0000000000
1_0_fe_00000000_3c_000000_0000000000_0000000000
1_0_fe_00000001_00_000000_0000000000_0000000000
4_4_0300_0000_00_30_00_00_000_000_0c4_000_00_ef_ef_61_3c
4_4_0000_0040_00_00_00_90_000_000_0c4_000_00_ff_fb_e1_3c
1_0_01_00000000_02_000000_0000000000_0000000000
4_0_0098_0204_00_00_00_00_012_000_0c4_000_00_eb_12_f3_3c
4_0_0000_0000_00_00_00_00_012_1a5_0c4_000_00_ff_a5_ff_3c
4_0_0000_0000_00_00_00_00_033_1a5_0c4_000_00_ff_33_ff_3c
1_0_01_00000000_07_000000_0000000000_0000000000
4_5_0410_0000_00_00_00_00_033_1a5_0c4_000_00_ff_ff_ff_3c

// ==== tb.f ====
logic/mcr3_pkg.sv
logic/rom_loader.sv
logic/config_regs.sv
logic/reset_sequencer.sv
logic/analog_select.sv
logic/input_mapper.sv
logic/mcr3_io_top.sv
tests/tb_mcr3_io.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module tb_mcr3_io \
	-o tb_mcr3_io_sim; then
	echo "Verilator compile failed"
	exit 1
fi

if ! ./obj_dir/tb_mcr3_io_sim; then
	echo "Simulation failed"
	exit 1
fi

echo "Simulation finished without errors"
exit 0
